//--- tb.f
+incdir+.
mac_rx_pkg.sv
xgmii_rx_decoder.sv
eth_header_parser.sv
eth_fcs_checker.sv
eth_rx_stream_out.sv
ten_gig_mac_rx.sv
tb_ten_gig_mac_rx.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the ten_gig_mac_rx testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_ten_gig_mac_rx \
    -f tb.f -o sim_tb || { echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

//--- tb_ten_gig_mac_rx.sv
`timescale 1ns/1ps
`include "mac_rx_macros.svh"

module tb_ten_gig_mac_rx;

    logic                    i_clk;
    logic                    i_rst;
    mac_rx_pkg::xgmii_word_t i_xgmii;
    mac_rx_pkg::frame_beat_t o_beat;
    mac_rx_pkg::rx_user_t    o_user;
    logic                    o_crc_valid;
    logic                    o_crc_error;

    mac_rx_pkg::frame_beat_t exp_beat_q[$];
    mac_rx_pkg::rx_user_t    exp_user_q[$];
    logic                    exp_err_q[$];
    logic [7:0]              pkt[0:255];
    integer                  seed;
    int                      frames_out;
    int                      crc_seen;
    logic                    out_busy;

    ten_gig_mac_rx ten_gig_mac_rx_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_xgmii     (i_xgmii),
        .o_beat      (o_beat),
        .o_user      (o_user),
        .o_crc_valid (o_crc_valid),
        .o_crc_error (o_crc_error)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    // Bitwise CRC-32 over pkt[0 .. len-1] giving the FCS
    function automatic logic [31:0] fcs_of(input int len);
        logic [31:0] crc;
        crc = `ETH_CRC_INIT;
        for (int i = 0; i < len; i++) begin
            for (int b = 0; b < 8; b++) begin
                if (crc[0] ^ pkt[i][b]) begin
                    crc = (crc >> 1) ^ `ETH_CRC_POLY;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge i_clk);
            i_xgmii.data <= {8{`XGMII_CTRL_IDLE}};
            i_xgmii.ctrl <= 8'hFF;
        end
    endtask

    ////////////////////
    // Frame builder
    // Symbols carry the ctrl flag in bit 8
    task automatic send_frame(input bit lane3, input int len, input bit bad_sfd,
                              input bit flip);
        logic [8:0]              sym_q[$];
        logic [8:0]              sym;
        logic [31:0]             fcs;
        mac_rx_pkg::xgmii_word_t word;
        mac_rx_pkg::frame_beat_t beat;
        mac_rx_pkg::rx_user_t    user;
        int                      nb;
        for (int i = 0; i < len; i++) begin
            pkt[i] = 8'($random(seed));
        end
        fcs = fcs_of(len);
        for (int i = 0; i < `ETH_FCS_BYTES; i++) begin
            pkt[len + i] = fcs[8*i +: 8];
        end
        // Payload error injected after the FCS is fixed
        if (flip) begin
            pkt[20] = ~pkt[20];
        end
        if (lane3) begin
            repeat (4) sym_q.push_back({1'b1, `XGMII_CTRL_IDLE});
        end
        sym_q.push_back({1'b1, `XGMII_CTRL_START});
        repeat (7) sym_q.push_back({1'b0, `ETH_PREAMBLE_BYTE});
        sym_q.push_back({1'b0, bad_sfd ? 8'hD4 : `ETH_SFD_BYTE});
        for (int i = 0; i < len + `ETH_FCS_BYTES; i++) begin
            sym_q.push_back({1'b0, pkt[i]});
        end
        sym_q.push_back({1'b1, `XGMII_CTRL_TERM});
        while (sym_q.size() % 8 != 0) begin
            sym_q.push_back({1'b1, `XGMII_CTRL_IDLE});
        end
        if (!bad_sfd) begin
            user.src_mac_lo = {pkt[10], pkt[11]};
            user.eth_type   = {pkt[12], pkt[13]};
            for (int b = 0; b < len; b += 8) begin
                nb         = (len - b < 8) ? len - b : 8;
                beat.valid = 1'b1;
                beat.last  = (b + 8 >= len);
                beat.keep  = 8'hFF << (8 - nb);
                beat.data  = '0;
                for (int k = 0; k < nb; k++) begin
                    beat.data[63 - 8*k -: 8] = pkt[b + k];
                end
                exp_beat_q.push_back(beat);
                exp_user_q.push_back(user);
            end
            exp_err_q.push_back(flip);
        end
        while (sym_q.size() > 0) begin
            for (int l = 7; l >= 0; l--) begin
                sym                    = sym_q.pop_front();
                word.ctrl[l]           = sym[8];
                word.data[8*l +: 8]    = sym[7:0];
            end
            @(negedge i_clk);
            i_xgmii <= word;
        end
    endtask

    ////////////////////
    // Output monitor
    initial begin
        mac_rx_pkg::frame_beat_t exp;
        mac_rx_pkg::rx_user_t    exp_user;
        logic                    exp_err;
        logic [63:0]             mask;
        forever begin
            @(negedge i_clk);
            if (!i_rst && o_beat.valid) begin
                assert (exp_beat_q.size() > 0)
                    else report_failure("Output beat arrived with no frame expected");
                assert (out_busy || crc_seen == frames_out)
                    else report_failure("New frame started before the previous CRC result");
                exp      = exp_beat_q.pop_front();
                exp_user = exp_user_q.pop_front();
                for (int l = 0; l < 8; l++) begin
                    mask[8*l +: 8] = {8{exp.keep[l]}};
                end
                assert (o_beat.keep == exp.keep && o_beat.last == exp.last)
                    else report_mismatch($sformatf("keep %h last %b, expected %h %b",
                        o_beat.keep, o_beat.last, exp.keep, exp.last));
                assert ((o_beat.data & mask) == (exp.data & mask))
                    else report_mismatch($sformatf("data %h, expected %h",
                        o_beat.data & mask, exp.data & mask));
                assert (o_user == exp_user)
                    else report_mismatch($sformatf("user %h, expected %h", o_user, exp_user));
                out_busy = !o_beat.last;
                if (o_beat.last) begin
                    frames_out++;
                end
            end
            if (!i_rst && o_crc_valid) begin
                assert (exp_err_q.size() > 0)
                    else report_failure("CRC result arrived with no frame expected");
                assert (crc_seen + 1 == frames_out)
                    else report_failure("CRC result came before the frame's last beat");
                crc_seen++;
                exp_err = exp_err_q.pop_front();
                assert (o_crc_error == exp_err)
                    else report_mismatch($sformatf("crc error %b, expected %b",
                        o_crc_error, exp_err));
            end
        end
    end

    initial begin
        int len;
        int waited;
        seed         = 33;
        frames_out   = 0;
        crc_seen     = 0;
        out_busy     = 1'b0;
        waited       = 0;
        i_rst        = 1'b1;
        i_xgmii.data = {8{`XGMII_CTRL_IDLE}};
        i_xgmii.ctrl = 8'hFF;
        repeat (3) @(negedge i_clk);
        assert (!o_beat.valid && !o_beat.last && o_beat.keep == '0 &&
                !o_crc_valid && !o_crc_error)
            else report_failure("Outputs not cleared by reset");
        i_rst = 1'b0;
        // Idle only so the monitor flags any output
        drive_idle(20);
        for (int n = 0; n < 16; n++) begin
            send_frame(n >= 8, 64 + n % 8, 1'b0, 1'b0);
            drive_idle(3);
        end
        for (int n = 0; n < 10; n++) begin
            len = 64 + int'({$random(seed)} % 87);
            send_frame(n[0], len, 1'b0, 1'b0);
            drive_idle(3);
        end
        send_frame(1'b0, 100, 1'b0, 1'b1);
        drive_idle(3);
        send_frame(1'b1, 77, 1'b0, 1'b1);
        drive_idle(3);
        // Bad SFD gives no output
        send_frame(1'b0, 90, 1'b1, 1'b0);
        drive_idle(10);
        send_frame(1'b0, 70, 1'b0, 1'b0);
        drive_idle(3);
        send_frame(1'b1, 81, 1'b1, 1'b0);
        drive_idle(10);
        send_frame(1'b1, 95, 1'b0, 1'b0);
        while ((exp_beat_q.size() > 0 || exp_err_q.size() > 0) && waited < 200) begin
            drive_idle(1);
            waited++;
        end
        if (exp_beat_q.size() > 0 || exp_err_q.size() > 0) begin
            report_failure("Timed out waiting for the remaining frames");
        end else begin
            drive_idle(5);
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- ten_gig_mac_rx.sv
`timescale 1ns/1ps

module ten_gig_mac_rx (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  mac_rx_pkg::xgmii_word_t i_xgmii,
    output mac_rx_pkg::frame_beat_t o_beat,
    output mac_rx_pkg::rx_user_t    o_user,
    output logic                    o_crc_valid,
    output logic                    o_crc_error
);

    mac_rx_pkg::frame_beat_t frame_beat;
    mac_rx_pkg::rx_user_t    hdr_user;

    xgmii_rx_decoder xgmii_rx_decoder_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_xgmii (i_xgmii),
        .o_beat  (frame_beat)
    );

    eth_header_parser eth_header_parser_i (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_beat (frame_beat),
        .o_user (hdr_user)
    );

    // CRC runs over the full beat stream including the FCS
    eth_fcs_checker eth_fcs_checker_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_beat      (frame_beat),
        .o_crc_valid (o_crc_valid),
        .o_crc_error (o_crc_error)
    );

    eth_rx_stream_out eth_rx_stream_out_i (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_beat (frame_beat),
        .i_user (hdr_user),
        .o_beat (o_beat),
        .o_user (o_user)
    );

endmodule

//--- eth_rx_stream_out.sv
`timescale 1ns/1ps
`include "mac_rx_macros.svh"

module eth_rx_stream_out (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  mac_rx_pkg::frame_beat_t i_beat,
    input  mac_rx_pkg::rx_user_t    i_user,
    output mac_rx_pkg::frame_beat_t o_beat,
    output mac_rx_pkg::rx_user_t    o_user
);

    mac_rx_pkg::frame_beat_t r_hold;

    logic                     short_tail;
    logic [`MAC_RX_LANES-1:0] held_keep;

    // Final beat carries FCS bytes only
    assign short_tail = i_beat.valid && i_beat.last &&
                        !i_beat.keep[`MAC_RX_LANES - `ETH_FCS_BYTES - 1];

    // Held beat loses the FCS bytes that did not reach the final beat
    assign held_keep = ({`MAC_RX_LANES{1'b1}} << `ETH_FCS_BYTES) |
                       (i_beat.keep >> `ETH_FCS_BYTES);

    // Parser word changes on the same edge as the first output beat
    assign o_user = i_user;

    ////////////////////
    // One beat held back
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_hold <= '0;
            o_beat <= '0;
        end else begin
            o_beat.valid <= 1'b0;
            o_beat.last  <= 1'b0;
            if (i_beat.valid) begin
                r_hold <= i_beat;
                if (short_tail) begin
                    r_hold.valid <= 1'b0;
                end
                if (r_hold.valid) begin
                    o_beat.valid <= 1'b1;
                    o_beat.data  <= r_hold.data;
                    o_beat.last  <= short_tail;
                    o_beat.keep  <= short_tail ? held_keep : r_hold.keep;
                end
            end else if (r_hold.valid) begin
                // Frame tail with more than four bytes
                o_beat.valid <= 1'b1;
                o_beat.data  <= r_hold.data;
                o_beat.last  <= 1'b1;
                o_beat.keep  <= r_hold.keep << `ETH_FCS_BYTES;
                r_hold.valid <= 1'b0;
            end
        end
    end

endmodule

//--- eth_fcs_checker.sv
`timescale 1ns/1ps
`include "mac_rx_macros.svh"

module eth_fcs_checker (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  mac_rx_pkg::frame_beat_t i_beat,
    output logic                    o_crc_valid,
    output logic                    o_crc_error
);

    logic [31:0] r_crc;
    logic [31:0] crc_next;
    logic        r_in_frame;
    logic        r_done;
    logic        r_pass;

    // One byte into the reflected register with bit 0 first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
                                             input logic [7:0]  data_in);
        logic [31:0] crc;
        crc = crc_in;
        for (int b = 0; b < 8; b++) begin
            if (crc[0] ^ data_in[b]) begin
                crc = (crc >> 1) ^ `ETH_CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        return crc;
    endfunction

    ////////////////////
    // Earliest lane first
    always_comb begin
        crc_next = r_in_frame ? r_crc : `ETH_CRC_INIT;
        for (int l = `MAC_RX_LANES - 1; l >= 0; l--) begin
            if (i_beat.keep[l]) begin
                crc_next = crc_byte(crc_next, i_beat.data[8*l +: 8]);
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_crc      <= `ETH_CRC_INIT;
            r_in_frame <= 1'b0;
            r_done     <= 1'b0;
            r_pass     <= 1'b0;
        end else begin
            r_done <= i_beat.valid && i_beat.last;
            if (i_beat.valid) begin
                r_crc      <= crc_next;
                r_in_frame <= !i_beat.last;
                if (i_beat.last) begin
                    r_pass <= (crc_next == `ETH_CRC_RESIDUE);
                end
            end
        end
    end

    ////////////////////
    // Result pulse
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_crc_valid <= 1'b0;
            o_crc_error <= 1'b0;
        end else begin
            o_crc_valid <= r_done;
            o_crc_error <= r_done && !r_pass;
        end
    end

endmodule

//--- eth_header_parser.sv
`timescale 1ns/1ps

module eth_header_parser (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  mac_rx_pkg::frame_beat_t i_beat,
    output mac_rx_pkg::rx_user_t    o_user
);

    // Saturates at 2 since only beats 0 and 1 matter
    logic [1:0] r_beat_cnt;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_beat_cnt <= 2'd0;
        end else if (i_beat.valid) begin
            if (i_beat.last) begin
                r_beat_cnt <= 2'd0;
            end else if (r_beat_cnt != 2'd2) begin
                r_beat_cnt <= r_beat_cnt + 2'd1;
            end
        end
    end

    ////////////////////
    // Beat 1 holds frame bytes 8 to 15
    // Bytes 10 and 11 end the source MAC and bytes 12 and 13 are the EtherType
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_user <= '0;
        end else if (i_beat.valid && (r_beat_cnt == 2'd1)) begin
            o_user.src_mac_lo <= i_beat.data[47:32];
            o_user.eth_type   <= i_beat.data[31:16];
        end
    end

endmodule

//--- xgmii_rx_decoder.sv
`timescale 1ns/1ps
`include "mac_rx_macros.svh"

module xgmii_rx_decoder (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  mac_rx_pkg::xgmii_word_t i_xgmii,
    output mac_rx_pkg::frame_beat_t o_beat
);

    mac_rx_pkg::xgmii_word_t r_xgmii_0;
    mac_rx_pkg::xgmii_word_t r_xgmii_1;
    mac_rx_pkg::xgmii_word_t r_xgmii_2;
    mac_rx_pkg::xgmii_word_t prev_word;
    mac_rx_pkg::xgmii_word_t cur_word;

    logic                      r_run;
    logic                      r_lane3;
    logic                      start7_ok;
    logic                      start3_ok;
    logic [`MAC_RX_LANES-1:0]  prev_term;
    logic [`MAC_RX_LANES-1:0]  cur_term;
    logic                      term_seen;
    logic [3:0]                term_bytes;
    logic [`MAC_RX_DATA_W-1:0] beat_data;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_xgmii_0 <= '0;
            r_xgmii_1 <= '0;
            r_xgmii_2 <= '0;
        end else begin
            r_xgmii_0 <= i_xgmii;
            r_xgmii_1 <= r_xgmii_0;
            r_xgmii_2 <= r_xgmii_1;
        end
    end

    ////////////////////
    // Start and preamble check
    assign start7_ok = (r_xgmii_1.ctrl == 8'h80) &&
                       (r_xgmii_1.data[63:56] == `XGMII_CTRL_START) &&
                       (r_xgmii_1.data[55:0] == {7{`ETH_PREAMBLE_BYTE}}) &&
                       !r_xgmii_0.ctrl[7] &&
                       (r_xgmii_0.data[63:56] == `ETH_SFD_BYTE);

    // Lane 3 start spills four preamble bytes and the SFD into the next word
    assign start3_ok = (r_xgmii_2.ctrl[3:0] == 4'b1000) &&
                       (r_xgmii_2.data[31:24] == `XGMII_CTRL_START) &&
                       (r_xgmii_2.data[23:0] == {3{`ETH_PREAMBLE_BYTE}}) &&
                       (r_xgmii_1.ctrl[7:3] == 5'd0) &&
                       (r_xgmii_1.data[63:32] == {4{`ETH_PREAMBLE_BYTE}}) &&
                       (r_xgmii_1.data[31:24] == `ETH_SFD_BYTE);

    ////////////////////
    // Realignment
    // Lane 3 frames run one word later
    assign prev_word = r_lane3 ? r_xgmii_2 : r_xgmii_1;
    assign cur_word  = r_lane3 ? r_xgmii_1 : r_xgmii_0;
    assign beat_data = r_lane3 ? {prev_word.data[23:0], cur_word.data[63:24]} :
                                 {prev_word.data[55:0], cur_word.data[63:56]};

    // Head bytes come from prev and the rest from cur
    always_comb begin
        int head;
        head       = r_lane3 ? 3 : 7;
        term_seen  = 1'b0;
        term_bytes = 4'd0;
        for (int l = 0; l < `MAC_RX_LANES; l++) begin
            prev_term[l] = prev_word.ctrl[l] &&
                           (prev_word.data[8*l +: 8] == `XGMII_CTRL_TERM);
            cur_term[l]  = cur_word.ctrl[l] &&
                           (cur_word.data[8*l +: 8] == `XGMII_CTRL_TERM);
            // Tail fits in this beat so the frame ends one beat early
            if (cur_term[l] && (l >= head - 1)) begin
                term_seen  = 1'b1;
                term_bytes = 4'(head + 7 - l);
            end
            if (prev_term[l] && (l <= head - 2)) begin
                term_seen  = 1'b1;
                term_bytes = 4'(head - 1 - l);
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_run   <= 1'b0;
            r_lane3 <= 1'b0;
            o_beat  <= '0;
        end else begin
            o_beat.valid <= r_run;
            o_beat.data  <= beat_data;
            o_beat.keep  <= '0;
            o_beat.last  <= r_run && term_seen;
            if (r_run) begin
                o_beat.keep <= term_seen ? ~({`MAC_RX_LANES{1'b1}} >> term_bytes) :
                                           {`MAC_RX_LANES{1'b1}};
                if (term_seen) begin
                    r_run <= 1'b0;
                end
            end else if (start7_ok) begin
                r_run   <= 1'b1;
                r_lane3 <= 1'b0;
            end else if (start3_ok) begin
                r_run   <= 1'b1;
                r_lane3 <= 1'b1;
            end
        end
    end

endmodule

//--- mac_rx_pkg.sv
`include "mac_rx_macros.svh"

package mac_rx_pkg;

    // One XGMII transfer
    // Ctrl bit n flags lane n as a control character
    typedef struct packed {
        logic [`MAC_RX_DATA_W-1:0] data;
        logic [`MAC_RX_LANES-1:0]  ctrl;
    } xgmii_word_t;

    // Realigned frame beat
    // keep[7] qualifies data[63:56] which holds the earliest byte
    typedef struct packed {
        logic                      valid;
        logic [`MAC_RX_DATA_W-1:0] data;
        logic [`MAC_RX_LANES-1:0]  keep;
        logic                      last;
    } frame_beat_t;

    // Sideband word shown with each delivered beat
    typedef struct packed {
        logic [15:0] src_mac_lo;
        logic [15:0] eth_type;
    } rx_user_t;

endpackage

//--- mac_rx_macros.svh
`ifndef MAC_RX_MACROS_SVH
`define MAC_RX_MACROS_SVH

// XGMII bus geometry
// Lane 7 carries the earliest byte
`define MAC_RX_DATA_W      64
`define MAC_RX_LANES       8

// Control characters
`define XGMII_CTRL_START   8'hFB
`define XGMII_CTRL_TERM    8'hFD
`define XGMII_CTRL_IDLE    8'h07

// Preamble and start of frame delimiter
`define ETH_PREAMBLE_BYTE  8'h55
`define ETH_SFD_BYTE       8'hD5

// Reflected CRC-32 shifted LSB first
`define ETH_CRC_POLY       32'hEDB88320
`define ETH_CRC_INIT       32'hFFFFFFFF
// Register contents after a good frame plus its FCS
`define ETH_CRC_RESIDUE    32'hDEBB20E3
`define ETH_FCS_BYTES      4

`endif
